// ==== all.f ====
+incdir+.
zmips_pkg.sv
zmips_fetch.sv
zmips_regfile.sv
zmips_decode.sv
zmips_alu.sv
zmips_execute.sv
zmips_hazard.sv
zmips_writeback.sv
zmips.sv
tb_zmips.sv

// ==== tb_zmips.sv ====
// zmips directed testbench
`timescale 1ns/1ns

module tb_zmips import zmips_pkg::*; ();

    localparam int CYCLE_LIMIT = 400;           // Five tests of at most 64 cycles plus margin

    // funct[5:3] codes inside each R group
    localparam logic [2:0] FN_AND  = 3'b000;
    localparam logic [2:0] FN_OR   = 3'b001;
    localparam logic [2:0] FN_XOR  = 3'b010;
    localparam logic [2:0] FN_ADD  = 3'b100;
    localparam logic [2:0] FN_SUB  = 3'b101;
    localparam logic [2:0] FN_PASS = 3'b000;    // Shift group
    localparam logic [2:0] FN_SLL  = 3'b001;
    localparam logic [2:0] FN_SRL  = 3'b010;
    localparam logic [2:0] FN_SRA  = 3'b011;

    logic  clk;
    logic  rst;
    word_t i_data;
    word_t i_addr;
    word_t d_data_i;
    word_t d_addr;
    word_t d_data_o;
    logic  d_wr;
    logic  d_rd;

    word_t imem [64];
    word_t dmem [256];
    word_t exp_addr [$];                        // Expected stores, in order
    word_t exp_data [$];
    int    prog_len;
    int    skip_left;                           // Instructions a modelled branch jumps over
    logic  live;                                // Last emitted instruction executes
    logic  loads_ok;                            // d_rd may rise in this test
    int    cycles;
    int    seed;
    logic  mz;                                  // Modelled flags
    logic  mc;
    logic  mn;

    zmips DUT (
        .clk      (clk),
        .rst      (rst),
        .i_data   (i_data),
        .i_addr   (i_addr),
        .d_data_i (d_data_i),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_wr     (d_wr),
        .d_rd     (d_rd)
    );

    always #4 clk = ~clk;

    assign i_data   = imem[i_addr[7:2]];        // Combinational instruction read
    assign d_data_i = dmem[d_addr[9:2]];

    always @(posedge clk)
    begin
        if (!rst && d_wr)
            dmem[d_addr[9:2]] <= d_data_o;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
            fail_run($sformatf("ERROR at %0t: %s is %h, expected %h",
                $time, what, actual, expected));
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
            fail_run("Timeout: the program did not produce all expected stores in time");
    end

    // Store monitor sampled mid-cycle where the port is stable
    always @(negedge clk)
    begin
        word_t ea;
        word_t ed;
        if (!rst)
        begin
            if (d_rd && !loads_ok)
                fail_run("Data read strobe rose in a program without loads");
            if (d_wr)
            begin
                if (exp_addr.size() == 0)
                    fail_run("A store reached memory where none was expected");
                else
                begin
                    ea = exp_addr.pop_front();
                    ed = exp_data.pop_front();
                    check(d_addr, ea, "store address");
                    check(d_data_o, ed, "store data");
                end
            end
        end
    end

    // Deterministic word derived from the whole byte address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f ^ (addr << 16);
    endfunction

    function automatic word_t sext26(input word_t v);
        return {{6{v[25]}}, v[25:0]};
    endfunction

    function automatic word_t r_word(input logic [3:0] op, input logic [4:0] rs,
        input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt,
        input logic [5:0] funct);
        return {2'b00, op, rs, rt, rd, shamt, funct};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
        live = (skip_left == 0);
        if (!live)
            skip_left--;
    endtask

    task automatic emit_li(input logic [25:0] imm);
        emit({2'b01, 4'b0000, imm});            // Into register 0
    endtask

    task automatic emit_alu(input logic [2:0] fn, input logic [4:0] rd,
        input logic [4:0] rs, input logic [4:0] rt);
        emit(r_word(4'b0100, rs, rt, rd, 5'd0, {fn, 3'b000}));
    endtask

    task automatic emit_shift(input logic [2:0] fn, input logic [4:0] rd,
        input logic [4:0] rs, input logic [4:0] sh);
        emit(r_word(4'b0101, rs, 5'd0, rd, sh, {fn, 3'b000}));
    endtask

    task automatic emit_store(input logic [4:0] addr_reg, input logic [4:0] data_reg);
        emit(r_word(4'b1001, addr_reg, data_reg, 5'd0, 5'd0, 6'd0));   // Address = rs
    endtask

    task automatic emit_load(input logic [4:0] rd, input logic [4:0] addr_reg);
        emit(r_word(4'b1101, addr_reg, 5'd0, rd, 5'd0, 6'd0));
    endtask

    task automatic emit_cmp(input logic [4:0] rs, input logic [4:0] rt);
        emit(r_word(4'b0000, rs, rt, 5'd0, 5'd0, {FN_SUB, 3'b111}));  // All flags
    endtask

    task automatic emit_force(input logic z, input logic c, input logic n);
        emit(r_word(4'b0010, 5'd0, 5'd0, 5'd0, 5'd0, {3'b000, z, c, n}));
        if (live)
        begin
            mz = z;
            mc = c;
            mn = n;
        end
    endtask

    // Condition code 0 is Z, 1 is C, 2 is N and 3 is always
    // Offset counts instructions after the branch
    task automatic emit_branch(input logic on_set, input logic [1:0] cc, input int offset);
        logic taken;
        case (cc)
            2'd0:    taken = (mz == on_set);
            2'd1:    taken = (mc == on_set);
            2'd2:    taken = (mn == on_set);
            default: taken = 1'b1;
        endcase
        emit({2'b10, on_set, 1'b0, cc, offset[25:0]});
        if (live && taken)
            skip_left = offset;
    endtask

    // Store data_reg at a loaded address and expect it only when it executes
    task automatic store_site(input word_t addr, input logic [4:0] data_reg, input word_t val);
        emit_li(addr[25:0]);
        emit_store(5'd0, data_reg);
        if (live)
        begin
            exp_addr.push_back(addr);
            exp_data.push_back(val);
        end
    endtask

    // Hold reset and clear memories and model before the caller builds a program
    task automatic start_test(input logic with_loads);
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 64; i++)
            imem[i] = '0;                       // NOP
        for (int i = 0; i < 256; i++)
            dmem[i] = fill_word(i << 2);
        exp_addr.delete();
        exp_data.delete();
        prog_len  = 0;
        skip_left = 0;
        live      = 1'b1;
        loads_ok  = with_loads;
        mz = 1'b0;                              // Flags clear out of reset
        mc = 1'b0;
        mn = 1'b0;
    endtask

    task automatic run_program();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        check(i_addr, '0, "i_addr after reset");
        check({31'd0, d_wr}, '0, "d_wr after reset");
        check({31'd0, d_rd}, '0, "d_rd after reset");
        while (exp_addr.size() > 0)
            @(posedge clk);
        repeat (8) @(posedge clk);              // Catch stray stores
    endtask

    task automatic test_reset_store();
        word_t v;
        start_test(1'b0);
        v = sext26($random(seed));
        emit_li(v[25:0]);
        emit_alu(FN_OR, 5'd1, 5'd0, 5'd0);
        store_site(32'h80, 5'd1, v);
        run_program();
    endtask

    task automatic test_alu_chain();
        word_t a;
        word_t b;
        word_t r3;
        word_t r4;
        word_t r5;
        word_t r6;
        start_test(1'b0);
        a  = sext26($random(seed));
        b  = sext26($random(seed));
        r3 = a & b;
        r4 = r3 ^ b;
        r5 = r4 + r3;
        r6 = r5 - r4 - 32'd1;                   // Carry flag still clear which borrows one
        emit_li(a[25:0]);
        emit_alu(FN_OR, 5'd1, 5'd0, 5'd0);
        emit_li(b[25:0]);
        emit_alu(FN_OR, 5'd2, 5'd0, 5'd0);
        emit_alu(FN_AND, 5'd3, 5'd1, 5'd2);     // r2 from EX/MEM, r1 from the register file
        emit_alu(FN_XOR, 5'd4, 5'd3, 5'd2);     // r3 from EX/MEM, r2 from MEM/WB
        emit_alu(FN_ADD, 5'd5, 5'd4, 5'd3);
        emit_alu(FN_SUB, 5'd6, 5'd5, 5'd4);
        store_site(32'h100, 5'd3, r3);
        store_site(32'h104, 5'd4, r4);
        store_site(32'h108, 5'd5, r5);
        store_site(32'h10c, 5'd6, r6);
        run_program();
    endtask

    task automatic test_shifts();
        word_t v;
        start_test(1'b0);
        v = sext26($random(seed) | 32'h0200_0000);   // Negative for SRA
        emit_li(v[25:0]);
        emit_shift(FN_SLL, 5'd1, 5'd0, 5'd7);
        emit_shift(FN_SRL, 5'd2, 5'd0, 5'd13);
        emit_shift(FN_SRA, 5'd3, 5'd0, 5'd5);
        emit_shift(FN_SRA, 5'd4, 5'd0, 5'd31);
        emit_shift(FN_PASS, 5'd5, 5'd0, 5'd9);  // Shamt ignored
        store_site(32'h180, 5'd1, v << 7);
        store_site(32'h184, 5'd2, v >> 13);
        store_site(32'h188, 5'd3, word_t'($signed(v) >>> 5));
        store_site(32'h18c, 5'd4, 32'hffff_ffff);
        store_site(32'h190, 5'd5, v);
        run_program();
    endtask

    task automatic test_load_use();
        word_t k;
        start_test(1'b1);
        k = sext26($random(seed));
        emit_li(k[25:0]);
        emit_alu(FN_OR, 5'd3, 5'd0, 5'd0);
        emit_li(26'h200);
        emit_load(5'd1, 5'd0);
        emit_alu(FN_ADD, 5'd2, 5'd1, 5'd3);     // Needs the stall
        store_site(32'h300, 5'd2, fill_word(32'h200) + k);
        run_program();
    endtask

    task automatic test_branches();
        word_t x;
        start_test(1'b0);
        x = sext26($random(seed));
        emit_li(x[25:0]);
        emit_alu(FN_OR, 5'd1, 5'd0, 5'd0);
        emit_cmp(5'd1, 5'd1);
        mz = 1'b1;                              // Equal operands with no borrow
        mc = 1'b1;
        mn = 1'b0;
        emit_branch(1'b1, 2'd0, 2);             // Flags straight from execute
        store_site(32'h40, 5'd1, x);
        store_site(32'h44, 5'd1, x);
        emit_branch(1'b0, 2'd0, 2);
        store_site(32'h48, 5'd1, x);
        emit_force(1'b0, 1'b1, 1'b0);
        emit_branch(1'b1, 2'd1, 2);
        store_site(32'h4c, 5'd1, x);
        emit_branch(1'b0, 2'd2, 2);
        store_site(32'h50, 5'd1, x);
        emit_force(1'b0, 1'b0, 1'b1);
        emit_branch(1'b0, 2'd2, 2);
        store_site(32'h54, 5'd1, x);
        emit_branch(1'b0, 2'd3, 2);             // Always
        store_site(32'h58, 5'd1, x);
        store_site(32'h5c, 5'd1, x);
        run_program();
    endtask

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        cycles   = 0;
        seed     = 32'h49b5;
        loads_ok = 1'b0;
        for (int i = 0; i < 64; i++)
            imem[i] = '0;
        for (int i = 0; i < 256; i++)
            dmem[i] = fill_word(i << 2);
        test_reset_store();
        test_alu_chain();
        test_shifts();
        test_load_use();
        test_branches();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== zmips.sv ====
// zmips five-stage core
`timescale 1ns/1ns

module zmips import zmips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t i_data,
    output word_t i_addr,
    input  word_t d_data_i,
    output word_t d_addr,
    output word_t d_data_o,
    output logic  d_wr,
    output logic  d_rd
);

    word_t     if_pc_plus;
    word_t     if_instr;
    word_t     branch_target;
    logic      take_branch;
    logic      branch_flush;
    logic      stall;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    flags_t    ex_flags;
    fwd_sel_e  rs_sel;
    fwd_sel_e  rt_sel;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;

    zmips_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .i_data        (i_data),
        .stall         (stall),
        .flush         (branch_flush),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .i_addr        (i_addr),
        .if_pc_plus    (if_pc_plus),
        .if_instr      (if_instr)
    );

    zmips_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .if_pc_plus    (if_pc_plus),
        .if_instr      (if_instr),
        .ex_flags      (ex_flags),
        .stall         (stall),
        .wb            (wb),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_ex         (id_ex),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .branch_flush  (branch_flush)
    );

    zmips_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .rs_sel   (rs_sel),
        .rt_sel   (rt_sel),
        .mem_fwd  (ex_mem.alu_result),
        .wb       (wb),
        .ex_flags (ex_flags),
        .ex_mem   (ex_mem)
    );

    zmips_hazard u_hazard (
        .clk          (clk),
        .rst          (rst),
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .id_ex_rd     (id_ex.rd),
        .id_ex_rs     (id_ex.rs),
        .id_ex_rt     (id_ex.rt),
        .id_ex_mem_rd (id_ex.mem_rd),
        .ex_mem_reg   (ex_mem.wb_reg),
        .mem_wb_reg   (wb.addr),
        .ex_mem_wr    (ex_mem.wr_reg),
        .mem_wb_wr    (wb.wr),
        .stall        (stall),
        .rs_sel       (rs_sel),
        .rt_sel       (rt_sel)
    );

    zmips_writeback u_writeback (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .d_data_i (d_data_i),
        .wb       (wb)
    );

    // Data port straight off EX/MEM
    assign d_addr   = ex_mem.alu_result;
    assign d_data_o = ex_mem.store_data;
    assign d_wr     = ex_mem.mem_wr;
    assign d_rd     = ex_mem.mem_rd;

endmodule

// ==== zmips_alu.sv ====
// Integer ALU with barrel shifter
`timescale 1ns/1ns

module zmips_alu import zmips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    input  shamt_t  shamt,
    input  logic    cin,                        // Inverted borrow for SUB
    output word_t   result,
    output logic    zero,
    output logic    carry
);

    always_comb
    begin
        result = '0;
        carry  = 1'b0;                          // Cleared unless add or subtract
        case (op)
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_ADD:  {carry, result} = {1'b0, a} + {1'b0, b};
            ALU_SUB:  {carry, result} = {1'b0, a} + {1'b0, ~b} + cin;
            ALU_PASS: result = a;               // Immediate load path
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== zmips_decode.sv ====
// Instruction decode stage
`timescale 1ns/1ns

module zmips_decode import zmips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     if_pc_plus,
    input  word_t     if_instr,
    input  flags_t    ex_flags,                 // Already forwarded from execute
    input  logic      stall,
    input  wb_t       wb,
    output reg_addr_t id_rs,
    output reg_addr_t id_rt,
    output id_ex_t    id_ex,
    output logic      take_branch,
    output word_t     branch_target,
    output logic      branch_flush
);

    logic [3:0] op;                             // Bits 29:26 below the format
    logic [5:0] funct;
    logic [1:0] cc;
    fmt_e       fmt;
    word_t      imm_se;
    word_t      rs_data;
    word_t      rt_data;
    logic       is_r;
    logic       is_imm;
    logic       is_branch;
    logic       flag_hit;
    id_ex_t     id_ex_d;

    assign fmt   = fmt_e'(if_instr[31:30]);
    assign op    = if_instr[29:26];
    assign cc    = if_instr[27:26];
    assign id_rs = if_instr[25:21];
    assign id_rt = if_instr[20:16];
    assign funct = if_instr[5:0];
    assign imm_se = {{($bits(word_t) - 26){if_instr[25]}}, if_instr[25:0]};

    // Register jump (funct all ones) and J-format fall out as no-ops
    assign is_r      = (fmt == FMT_R) && !(&funct);
    assign is_imm    = (fmt == FMT_IMM_LOAD);
    assign is_branch = (fmt == FMT_BRANCH);

    zmips_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs      (id_rs),
        .rt      (id_rt),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // Bit 29 picks branch on set or on clear
    always_comb
    begin
        case (cc)
            2'b00:   flag_hit = ex_flags.z ~^ if_instr[29];
            2'b01:   flag_hit = ex_flags.c ~^ if_instr[29];
            2'b10:   flag_hit = ex_flags.n ~^ if_instr[29];
            default: flag_hit = 1'b1;           // Always
        endcase
    end

    assign take_branch   = is_branch & flag_hit;
    assign branch_target = if_pc_plus + (imm_se << 2);
    assign branch_flush  = is_branch;           // One bubble per branch

    always_comb
    begin
        id_ex_d.reg_a       = rs_data;
        id_ex_d.reg_b       = rt_data;
        id_ex_d.immediate   = imm_se;
        id_ex_d.rs          = id_rs;
        id_ex_d.rt          = id_rt;
        id_ex_d.rd          = is_imm ? '0 : if_instr[15:11];   // Immediate goes to r0
        id_ex_d.alu_op      = is_imm ? ALU_PASS : alu_op_e'({op[0], funct[5:3]});
        id_ex_d.shamt       = if_instr[10:6];
        id_ex_d.alu_src     = is_imm;
        id_ex_d.mem_rd      = is_r & op[3] & op[2];            // Load
        id_ex_d.mem_wr      = is_r & op[3] & ~op[2];           // Store
        id_ex_d.wr_reg      = is_imm | (is_r & op[2]);
        id_ex_d.flag_wr     = is_r ? flags_t'(funct[2:0]) : '0;
        id_ex_d.force_flags = is_r & op[1];

        // Stall, branch or no-op leaves a bubble behind
        if (stall || !(is_r || is_imm))
        begin
            id_ex_d.alu_src     = 1'b0;
            id_ex_d.mem_rd      = 1'b0;
            id_ex_d.mem_wr      = 1'b0;
            id_ex_d.wr_reg      = 1'b0;
            id_ex_d.flag_wr     = '0;
            id_ex_d.force_flags = 1'b0;
        end
    end

    // ID/EX register, control bits cleared by reset
    always_ff @(posedge clk)
    begin
        id_ex <= id_ex_d;
        if (rst)
        begin
            id_ex.alu_src     <= 1'b0;
            id_ex.mem_rd      <= 1'b0;
            id_ex.mem_wr      <= 1'b0;
            id_ex.wr_reg      <= 1'b0;
            id_ex.flag_wr     <= '0;
            id_ex.force_flags <= 1'b0;
        end
    end

endmodule

// ==== zmips_defs.svh ====
// zmips core parameters
`ifndef ZMIPS_DEFS_SVH
`define ZMIPS_DEFS_SVH

// Data, address and instruction width
`define ZMIPS_XLEN 32

// General purpose registers, register 0 included
`define ZMIPS_NREGS 32

// First fetch address out of reset
`define ZMIPS_RESET_PC 32'h0000_0000

// Byte step between instructions
`define ZMIPS_PC_STEP 32'd4

`endif

// ==== zmips_execute.sv ====
// Execute stage with flag registers
`timescale 1ns/1ns

module zmips_execute import zmips_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  id_ex_t   id_ex,
    input  fwd_sel_e rs_sel,
    input  fwd_sel_e rt_sel,
    input  word_t    mem_fwd,                   // EX/MEM ALU result
    input  wb_t      wb,
    output flags_t   ex_flags,                  // Next flag state, seen by a branch in decode
    output ex_mem_t  ex_mem
);

    flags_t flags_q;
    flags_t alu_flags;
    flags_t new_flags;
    flags_t flag_en;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_a;
    word_t  alu_result;
    logic   alu_zero;
    logic   alu_carry;
    logic   cin;

    function automatic word_t fwd_operand(input fwd_sel_e sel, input word_t rf_val);
        case (sel)
            FWD_MEMORY:    return mem_fwd;
            FWD_WRITEBACK: return wb.data;
            default:       return rf_val;
        endcase
    endfunction

    always_comb
    begin
        op_a  = fwd_operand(rs_sel, id_ex.reg_a);
        op_b  = fwd_operand(rt_sel, id_ex.reg_b);   // Also the store data
        alu_a = id_ex.alu_src ? id_ex.immediate : op_a;
    end

    assign cin = !id_ex.wr_reg | flags_q.c;     // Compare subtracts with no borrow

    zmips_alu u_alu (
        .a      (alu_a),
        .b      (op_b),
        .op     (id_ex.alu_op),
        .shamt  (id_ex.shamt),
        .cin    (cin),
        .result (alu_result),
        .zero   (alu_zero),
        .carry  (alu_carry)
    );

    always_comb
    begin
        alu_flags = '{z: alu_zero, c: alu_carry, n: alu_result[$bits(word_t)-1]};
        new_flags = id_ex.force_flags ? id_ex.flag_wr : alu_flags;
        flag_en   = id_ex.flag_wr | {3{id_ex.force_flags}};
        ex_flags  = (new_flags & flag_en) | (flags_q & ~flag_en);   // Per-flag enable
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            flags_q <= '0;
        else
            flags_q <= ex_flags;
    end

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= op_b;
        ex_mem.wb_reg     <= id_ex.rd;
        ex_mem.mem_rd     <= id_ex.mem_rd & !rst;
        ex_mem.mem_wr     <= id_ex.mem_wr & !rst;
        ex_mem.wr_reg     <= id_ex.wr_reg & !rst;
    end

    // Decode never issues a load and a store at once
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(ex_mem.mem_rd && ex_mem.mem_wr));

endmodule

// ==== zmips_fetch.sv ====
// Instruction fetch stage
`timescale 1ns/1ns
`include "zmips_defs.svh"

module zmips_fetch import zmips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t i_data,
    input  logic  stall,                        // Load-use hold
    input  logic  flush,                        // Branch in decode
    input  logic  take_branch,
    input  word_t branch_target,
    output word_t i_addr,
    output word_t if_pc_plus,
    output word_t if_instr
);

    word_t pc;
    word_t pc_next;

    assign i_addr = pc;                         // Combinational instruction read

    always_comb
    begin
        if (take_branch)
            pc_next = branch_target;
        else if (flush)
            pc_next = if_pc_plus;               // Not taken, refetch the slot behind the branch
        else
            pc_next = pc + `ZMIPS_PC_STEP;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc       <= `ZMIPS_RESET_PC;
            if_instr <= '0;                     // NOP
        end
        else if (!stall)
        begin
            pc       <= pc_next;
            if_instr <= flush ? '0 : i_data;    // Kill the slot after a branch
        end
    end

    // Return address of the fetched word
    always_ff @(posedge clk)
    begin
        if (!stall)
            if_pc_plus <= pc + `ZMIPS_PC_STEP;
    end

    // Branch targets from decode keep the PC on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== zmips_hazard.sv ====
// Load-use stall and operand forwarding
`timescale 1ns/1ns

module zmips_hazard import zmips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  reg_addr_t id_ex_rd,
    input  reg_addr_t id_ex_rs,
    input  reg_addr_t id_ex_rt,
    input  logic      id_ex_mem_rd,
    input  reg_addr_t ex_mem_reg,
    input  reg_addr_t mem_wb_reg,
    input  logic      ex_mem_wr,
    input  logic      mem_wb_wr,
    output logic      stall,
    output fwd_sel_e  rs_sel,
    output fwd_sel_e  rt_sel
);

    // Youngest producer wins
    function automatic fwd_sel_e fwd_pick(input reg_addr_t src);
        if (ex_mem_wr && ex_mem_reg == src)
            return FWD_MEMORY;
        else if (mem_wb_wr && mem_wb_reg == src)
            return FWD_WRITEBACK;
        else
            return FWD_REGFILE;
    endfunction

    // Load in execute feeding decode
    assign stall = id_ex_mem_rd && (id_ex_rd == id_rs || id_ex_rd == id_rt);

    always_comb
    begin
        rs_sel = fwd_pick(id_ex_rs);
        rt_sel = fwd_pick(id_ex_rt);
    end

    // The bubble behind a stall carries no load
    a_single_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

// ==== zmips_pkg.sv ====
// zmips shared types
`include "zmips_defs.svh"

package zmips_pkg;

    typedef logic [`ZMIPS_XLEN-1:0] word_t;    // Data, address or instruction
    typedef logic [4:0] reg_addr_t;             // Register number
    typedef logic [4:0] shamt_t;                // Shift amount

    // Instruction format, bits 31:30
    typedef enum logic [1:0] {
        FMT_R        = 2'b00,
        FMT_IMM_LOAD = 2'b01,
        FMT_BRANCH   = 2'b10,
        FMT_JUMP     = 2'b11                    // Decodes as a no-op
    } fmt_e;

    // ALU operation, {op[0], funct[5:3]}; bit 3 picks the shift group
    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_OR   = 4'b0001,
        ALU_XOR  = 4'b0010,
        ALU_ADD  = 4'b0100,
        ALU_SUB  = 4'b0101,
        ALU_PASS = 4'b1000,                     // Shift group with no shift
        ALU_SLL  = 4'b1001,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_REGFILE   = 2'd0,
        FWD_WRITEBACK = 2'd1,
        FWD_MEMORY    = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
    } flags_t;

    typedef struct packed {
        word_t     reg_a;                       // Register file rs value
        word_t     reg_b;                       // Register file rt value
        word_t     immediate;                   // Sign-extended 26-bit field
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        alu_op_e   alu_op;
        shamt_t    shamt;
        logic      alu_src;                     // ALU a from the immediate
        logic      mem_rd;
        logic      mem_wr;
        logic      wr_reg;
        flags_t    flag_wr;                     // Flag enables, or forced values
        logic      force_flags;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;                  // Also the data address
        word_t     store_data;
        reg_addr_t wb_reg;
        logic      mem_rd;
        logic      mem_wr;
        logic      wr_reg;
    } ex_mem_t;

    typedef struct packed {
        word_t     mem_data;
        word_t     alu_data;
        reg_addr_t wb_reg;
        logic      mem_rd;
        logic      wr_reg;
    } mem_wb_t;

    // Write-back port, also the last forwarding source
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

// ==== zmips_regfile.sv ====
// General purpose register file
`timescale 1ns/1ns
`include "zmips_defs.svh"

module zmips_regfile import zmips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  wb_t       wb,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [`ZMIPS_NREGS];                 // Register 0 is an ordinary register

    always_ff @(posedge clk)
    begin
        if (!rst && wb.wr)                      // Writes ignored while in reset
            regs[wb.addr] <= wb.data;
    end

    // Same-cycle write shows through, so decode never reads a stale value
    assign rs_data = (wb.wr && wb.addr == rs) ? wb.data : regs[rs];
    assign rt_data = (wb.wr && wb.addr == rt) ? wb.data : regs[rt];

endmodule

// ==== zmips_writeback.sv ====
// Memory to write-back stage
`timescale 1ns/1ns

module zmips_writeback import zmips_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    input  word_t   d_data_i,                   // Load data, same cycle as d_rd
    output wb_t     wb
);

    mem_wb_t mem_wb;

    always_ff @(posedge clk)
    begin
        mem_wb.mem_data <= d_data_i;
        mem_wb.alu_data <= ex_mem.alu_result;
        mem_wb.wb_reg   <= ex_mem.wb_reg;
        if (rst)
        begin
            mem_wb.mem_rd <= 1'b0;
            mem_wb.wr_reg <= 1'b0;
        end
        else
        begin
            mem_wb.mem_rd <= ex_mem.mem_rd;
            mem_wb.wr_reg <= ex_mem.wr_reg;
        end
    end

    assign wb = '{
        wr:   mem_wb.wr_reg,
        addr: mem_wb.wb_reg,
        data: mem_wb.mem_rd ? mem_wb.mem_data : mem_wb.alu_data
    };

    // A write needs a known destination from decode
    a_wb_addr_known: assert property (@(posedge clk) disable iff (rst)
        mem_wb.wr_reg |-> !$isunknown(mem_wb.wb_reg));

endmodule
